//--- hw/mouse_params.svh
/* screen geometry in pixels and the PS/2 frame timeout in dav cycles
   the timeout assumes dav runs far faster than the 10-16.7 kHz PS/2 clock */
`ifndef MOUSE_PARAMS_SVH
`define MOUSE_PARAMS_SVH

// visible area, clamp limits are one less
`define MOUSE_SCREEN_W 640
`define MOUSE_SCREEN_H 480

// position after reset and after a two-button recentre
`define MOUSE_HOME_X 320
`define MOUSE_HOME_Y 240

// dav cycles without a PS/2 clock fall before a partial frame is dropped
`define MOUSE_PS2_IDLE_CYCLES 2000

`endif

//--- hw/mouse_pkg.sv
/* shared types of the mouse display chain
   coordinates are unsigned pixels, deltas are 9-bit two's complement */
`default_nettype none

package mouse_pkg;

	typedef logic [10:0] coord_t;        // one screen coordinate
	typedef logic signed [8:0] delta_t;  // sign bit from byte 0, low byte from byte 1/2
	typedef logic [3:0] bcd_digit_t;
	typedef logic [7:0] ps2_byte_t;

	typedef struct packed {
		logic left;
		logic right;
		delta_t dx;
		delta_t dy;   // positive moves y up the count
	} mouse_packet_t;

	typedef struct packed {
		coord_t x;
		coord_t y;
	} position_t;

	typedef struct packed {
		bcd_digit_t x_hund;
		bcd_digit_t x_tens;
		bcd_digit_t x_unit;
		bcd_digit_t y_hund;
		bcd_digit_t y_tens;
		bcd_digit_t y_unit;
	} bcd_pos_t;

	typedef enum logic [1:0] {RX_IDLE, RX_DATA, RX_PARITY, RX_STOP} rx_state_t;
	typedef enum logic [1:0] {ASM_BYTE0, ASM_BYTE1, ASM_BYTE2} asm_state_t;
	typedef enum logic [2:0] {BCD_IDLE, BCD_HUND, BCD_TENS, BCD_REQ, BCD_WAIT_ACK_LOW} bcd_state_t;

endpackage

`default_nettype wire

//--- hw/ps2_rx.sv
/* device-to-host frames only, the mouse must already be streaming
   a frame stalled longer than MOUSE_PS2_IDLE_CYCLES is dropped with byte_err */
`default_nettype none
`include "mouse_params.svh"

module ps2_rx
	import mouse_pkg::*;
(
	input  logic      dav,
	input  logic      rst,
	input  logic      ps2_clk,
	input  logic      ps2_data,
	output ps2_byte_t rx_byte,
	output logic      byte_valid,
	output logic      byte_err
);

	localparam int IDLE_W = $clog2(`MOUSE_PS2_IDLE_CYCLES + 1);

	rx_state_t state;
	logic [1:0] clk_sync;     // two-stage synchroniser
	logic [1:0] data_sync;
	logic clk_prev;           // edge register
	logic fall;
	logic [2:0] bit_cnt;
	ps2_byte_t shift;
	logic parity_ok;
	logic [IDLE_W-1:0] idle_cnt;

	assign fall = clk_prev & ~clk_sync[1];
	assign rx_byte = shift;   // held until the next frame's data bits

	always_ff @(posedge dav)
	begin
		if (rst)
		begin
			clk_sync <= 2'b11;   // lines idle high
			data_sync <= 2'b11;
			clk_prev <= 1'b1;
		end
		else
		begin
			clk_sync <= {clk_sync[0], ps2_clk};
			data_sync <= {data_sync[0], ps2_data};
			clk_prev <= clk_sync[1];
		end
	end

	always_ff @(posedge dav)
	begin
		byte_valid <= 1'b0;
		byte_err <= 1'b0;
		if (rst)
		begin
			state <= RX_IDLE;
			bit_cnt <= '0;
			idle_cnt <= '0;
		end
		else if (state != RX_IDLE && !fall &&
			idle_cnt == IDLE_W'(`MOUSE_PS2_IDLE_CYCLES - 1))
		begin
			byte_err <= 1'b1;    // stalled frame
			state <= RX_IDLE;
		end
		else
		begin
			if (fall || state == RX_IDLE)
				idle_cnt <= '0;
			else
				idle_cnt <= idle_cnt + 1'b1;

			if (fall)
			begin
				case (state)
					RX_IDLE:
						if (!data_sync[1])
						begin
							bit_cnt <= '0;
							state <= RX_DATA;
						end
						else
							byte_err <= 1'b1;    // bad start bit
					RX_DATA:
					begin
						shift <= {data_sync[1], shift[7:1]};   // lsb first
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7)
							state <= RX_PARITY;
					end
					RX_PARITY:
					begin
						parity_ok <= ^{shift, data_sync[1]};   // odd parity
						state <= RX_STOP;
					end
					RX_STOP:
					begin
						if (data_sync[1] && parity_ok)
							byte_valid <= 1'b1;
						else
							byte_err <= 1'b1;
						state <= RX_IDLE;
					end
				endcase
			end
		end
	end

	a_valid_err_excl: assert property (@(posedge dav) disable iff (rst)
		!(byte_valid && byte_err));

endmodule

`default_nettype wire

//--- hw/packet_assembler.sv
/* standard 3-byte packets only, no wheel byte; overflow bits are ignored
   byte 0 must carry bit 3 set, otherwise it is skipped to regain sync */
`default_nettype none

module packet_assembler
	import mouse_pkg::*;
(
	input  logic          dav,
	input  logic          rst,
	input  ps2_byte_t     rx_byte,
	input  logic          byte_valid,
	input  logic          byte_err,
	output mouse_packet_t packet,
	output logic          packet_valid
);

	asm_state_t state;
	logic left;
	logic right;
	logic x_sign;
	logic y_sign;
	ps2_byte_t dx_lo;

	always_ff @(posedge dav)
	begin
		packet_valid <= 1'b0;
		if (rst)
			state <= ASM_BYTE0;
		else if (byte_err)
			state <= ASM_BYTE0;    // drop partial packet
		else if (byte_valid)
		begin
			case (state)
				ASM_BYTE0:
					if (rx_byte[3])    // sync bit
					begin
						left <= rx_byte[0];
						right <= rx_byte[1];
						x_sign <= rx_byte[4];
						y_sign <= rx_byte[5];
						state <= ASM_BYTE1;
					end
				ASM_BYTE1:
				begin
					dx_lo <= rx_byte;
					state <= ASM_BYTE2;
				end
				ASM_BYTE2:
				begin
					packet.left <= left;
					packet.right <= right;
					packet.dx <= {x_sign, dx_lo};
					packet.dy <= {y_sign, rx_byte};
					packet_valid <= 1'b1;
					state <= ASM_BYTE0;
				end
				default:
					state <= ASM_BYTE0;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hw/position_tracker.sv
/* a positive dy increases y; both buttons held move the start point to home
   before the packet's deltas are applied */
`default_nettype none
`include "mouse_params.svh"

module position_tracker
	import mouse_pkg::*;
(
	input  logic          dav,
	input  logic          rst,
	input  mouse_packet_t packet,
	input  logic          packet_valid,
	output position_t     pos,
	output logic          pos_valid
);

	position_t start;
	logic signed [12:0] sum_x;   // wide enough for 639 + 255 and 0 - 256
	logic signed [12:0] sum_y;
	coord_t next_x;
	coord_t next_y;

	function automatic coord_t clamp(input logic signed [12:0] v, input int hi);
		if (v < 0)
			return '0;
		else if (v > hi)
			return coord_t'(hi);
		else
			return coord_t'(v);
	endfunction

	always_comb
	begin
		start = pos;
		if (packet.left && packet.right)
		begin
			start.x = coord_t'(`MOUSE_HOME_X);   // recentre
			start.y = coord_t'(`MOUSE_HOME_Y);
		end
		sum_x = $signed({2'b00, start.x}) + $signed({{4{packet.dx[8]}}, packet.dx});
		sum_y = $signed({2'b00, start.y}) + $signed({{4{packet.dy[8]}}, packet.dy});
		next_x = clamp(sum_x, `MOUSE_SCREEN_W - 1);
		next_y = clamp(sum_y, `MOUSE_SCREEN_H - 1);
	end

	always_ff @(posedge dav)
	begin
		if (rst)
		begin
			pos.x <= coord_t'(`MOUSE_HOME_X);
			pos.y <= coord_t'(`MOUSE_HOME_Y);
			pos_valid <= 1'b0;
		end
		else
		begin
			pos_valid <= packet_valid;   // also for packets that do not move
			if (packet_valid)
			begin
				pos.x <= next_x;
				pos.y <= next_y;
			end
		end
	end

	a_pos_on_screen: assert property (@(posedge dav) disable iff (rst)
		pos.x < `MOUSE_SCREEN_W && pos.y < `MOUSE_SCREEN_H);

endmodule

`default_nettype wire

//--- hw/bcd_converter.sv
/* only the newest position is kept while busy, so fast moves may skip values
   disp_req may rise again only after disp_ack has fallen */
`default_nettype none

module bcd_converter
	import mouse_pkg::*;
(
	input  logic      dav,
	input  logic      rst,
	input  position_t pos,
	input  logic      pos_valid,
	output bcd_pos_t  disp_data,
	output logic      disp_req,
	input  logic      disp_ack
);

	bcd_state_t state;
	position_t pend_pos;   // one-entry pending register
	logic pend;
	coord_t work_x;
	coord_t work_y;
	bcd_digit_t x_hund;    // running hundreds and tens
	bcd_digit_t x_tens;
	bcd_digit_t y_hund;
	bcd_digit_t y_tens;

	always_ff @(posedge dav)
	begin
		if (pos_valid)
			pend_pos <= pos;   // newest wins
		if (rst)
		begin
			state <= BCD_IDLE;
			pend <= 1'b0;
			disp_req <= 1'b0;
		end
		else
		begin
			if (pos_valid)
				pend <= 1'b1;
			case (state)
				BCD_IDLE:
					if (pend)
					begin
						work_x <= pend_pos.x;
						work_y <= pend_pos.y;
						x_hund <= '0;
						x_tens <= '0;
						y_hund <= '0;
						y_tens <= '0;
						pend <= pos_valid;   // a fresh arrival stays pending
						state <= BCD_HUND;
					end
				BCD_HUND:
				begin
					if (work_x >= 11'd100)
					begin
						work_x <= work_x - 11'd100;
						x_hund <= x_hund + 1'b1;
					end
					if (work_y >= 11'd100)
					begin
						work_y <= work_y - 11'd100;
						y_hund <= y_hund + 1'b1;
					end
					if (work_x < 11'd100 && work_y < 11'd100)
						state <= BCD_TENS;
				end
				BCD_TENS:
				begin
					if (work_x >= 11'd10)
					begin
						work_x <= work_x - 11'd10;
						x_tens <= x_tens + 1'b1;
					end
					if (work_y >= 11'd10)
					begin
						work_y <= work_y - 11'd10;
						y_tens <= y_tens + 1'b1;
					end
					if (work_x < 11'd10 && work_y < 11'd10)
					begin
						disp_data.x_hund <= x_hund;
						disp_data.x_tens <= x_tens;
						disp_data.x_unit <= bcd_digit_t'(work_x);   // remainder
						disp_data.y_hund <= y_hund;
						disp_data.y_tens <= y_tens;
						disp_data.y_unit <= bcd_digit_t'(work_y);
						disp_req <= 1'b1;
						state <= BCD_REQ;
					end
				end
				BCD_REQ:
					if (disp_ack)
					begin
						disp_req <= 1'b0;
						state <= BCD_WAIT_ACK_LOW;
					end
				BCD_WAIT_ACK_LOW:
					if (!disp_ack)
						state <= BCD_IDLE;
				default:
					state <= BCD_IDLE;
			endcase
		end
	end

	a_data_stable: assert property (@(posedge dav) disable iff (rst)
		disp_req |=> !disp_req || $stable(disp_data));

	a_digit_range: assert property (@(posedge dav) disable iff (rst)
		disp_req |-> disp_data.x_hund <= 4'd9 && disp_data.x_tens <= 4'd9 &&
		disp_data.x_unit <= 4'd9 && disp_data.y_hund <= 4'd9 &&
		disp_data.y_tens <= 4'd9 && disp_data.y_unit <= 4'd9);

endmodule

`default_nettype wire

//--- hw/mouse_display_top.sv
/* PS/2 mouse to six-digit position display, receive path only
   stages pass one-cycle valid pulses, the display side uses four-phase req/ack */
`default_nettype none

module mouse_display_top
	import mouse_pkg::*;
(
	input  logic     dav,
	input  logic     rst,
	input  logic     ps2_clk,
	input  logic     ps2_data,
	output bcd_pos_t disp_data,
	output logic     disp_req,
	input  logic     disp_ack
);

	ps2_byte_t rx_byte;
	logic byte_valid;
	logic byte_err;
	mouse_packet_t packet;
	logic packet_valid;
	position_t pos;
	logic pos_valid;

	ps2_rx i_ps2_rx (
		.dav        (dav),
		.rst        (rst),
		.ps2_clk    (ps2_clk),
		.ps2_data   (ps2_data),
		.rx_byte    (rx_byte),
		.byte_valid (byte_valid),
		.byte_err   (byte_err)
	);

	packet_assembler i_packet_assembler (
		.dav          (dav),
		.rst          (rst),
		.rx_byte      (rx_byte),
		.byte_valid   (byte_valid),
		.byte_err     (byte_err),
		.packet       (packet),
		.packet_valid (packet_valid)
	);

	position_tracker i_position_tracker (
		.dav          (dav),
		.rst          (rst),
		.packet       (packet),
		.packet_valid (packet_valid),
		.pos          (pos),
		.pos_valid    (pos_valid)
	);

	bcd_converter i_bcd_converter (
		.dav       (dav),
		.rst       (rst),
		.pos       (pos),
		.pos_valid (pos_valid),
		.disp_data (disp_data),
		.disp_req  (disp_req),
		.disp_ack  (disp_ack)
	);

endmodule

`default_nettype wire

//--- verif/tb_mouse_display.sv
/* drives PS/2 frames into the top level and checks the six displayed digits
   displays are matched in order against a queue, skipped positions are allowed */
`default_nettype none
`include "mouse_params.svh"

module tb_mouse_display
	import mouse_pkg::*;
;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int NUM_PACKETS = 50;
	localparam real LIMIT_NS = NUM_PACKETS * 33 * 40 * 4 * 1.5;

	logic dav;
	logic rst;
	logic ps2_clk;
	logic ps2_data;
	logic disp_ack;
	logic disp_req;
	bcd_pos_t disp_data;

	position_t model_pos;
	bcd_pos_t exp_q[$];
	bcd_pos_t last_disp;
	logic req_prev;
	int req_count;
	int errors;
	int test_start_errors;
	int tests_passed;
	int tests_failed;

	mouse_display_top i_mouse_display_top (
		.dav       (dav),
		.rst       (rst),
		.ps2_clk   (ps2_clk),
		.ps2_data  (ps2_data),
		.disp_data (disp_data),
		.disp_req  (disp_req),
		.disp_ack  (disp_ack)
	);

	initial
	begin
		dav = 1'b0;
		forever #2 dav = ~dav;
	end

	task automatic step(input int n);
		repeat (n) @(posedge dav);
		#1;   // inputs move just after the edge
	endtask

	// tracker rule: home start on both buttons, signed add, clamp to the screen
	function automatic position_t next_pos(input position_t p, input mouse_packet_t k);
		position_t r;
		int sx;
		int sy;
		sx = (k.left && k.right) ? `MOUSE_HOME_X : int'(p.x);
		sy = (k.left && k.right) ? `MOUSE_HOME_Y : int'(p.y);
		sx = sx + int'($signed(k.dx));
		sy = sy + int'($signed(k.dy));
		sx = (sx < 0) ? 0 : (sx > `MOUSE_SCREEN_W - 1) ? `MOUSE_SCREEN_W - 1 : sx;
		sy = (sy < 0) ? 0 : (sy > `MOUSE_SCREEN_H - 1) ? `MOUSE_SCREEN_H - 1 : sy;
		r.x = coord_t'(sx);
		r.y = coord_t'(sy);
		return r;
	endfunction

	function automatic bcd_pos_t to_digits(input position_t p);
		bcd_pos_t d;
		d.x_hund = bcd_digit_t'(p.x / 100);
		d.x_tens = bcd_digit_t'((p.x / 10) % 10);
		d.x_unit = bcd_digit_t'(p.x % 10);
		d.y_hund = bcd_digit_t'(p.y / 100);
		d.y_tens = bcd_digit_t'((p.y / 10) % 10);
		d.y_unit = bcd_digit_t'(p.y % 10);
		return d;
	endfunction

	// start, 8 data lsb first, odd parity, stop
	task automatic send_frame(input ps2_byte_t b, input logic bad_parity);
		logic [10:0] bits;
		bits = {1'b1, ~^b ^ bad_parity, b, 1'b0};
		for (int i = 0; i < 11; i++)
		begin
			ps2_data = bits[i];   // change while clock is high
			step(10);
			ps2_clk = 1'b0;
			step(20);
			ps2_clk = 1'b1;
			step(10);
		end
	endtask

	task automatic send_packet(input logic left, input logic right, input delta_t dx,
		input delta_t dy, input logic bad);
		mouse_packet_t k;
		k.left = left;
		k.right = right;
		k.dx = dx;
		k.dy = dy;
		if (!bad)
		begin
			model_pos = next_pos(model_pos, k);
			exp_q.push_back(to_digits(model_pos));   // queued before the DUT can show it
		end
		send_frame({2'b00, dy[8], dx[8], 1'b1, 1'b0, right, left}, 1'b0);
		step(10);
		send_frame(dx[7:0], bad);   // corrupt parity of the dx byte
		step(10);
		send_frame(dy[7:0], 1'b0);
	endtask

	task automatic wait_display(input bcd_pos_t exp);
		int n;
		n = 0;
		while (last_disp != exp && n < 400)
		begin
			step(1);
			n++;
		end
		assert (last_disp == exp)
		else
		begin
			errors++;
			$display("Fail disp_data expected %h got %h", exp, last_disp);
		end
		while (disp_req || disp_ack)
			step(1);   // let the handshake close
	endtask

	task automatic end_test(input string name);
		if (errors == test_start_errors)
		begin
			tests_passed++;
			$display("test %s: ok", name);
		end
		else
		begin
			tests_failed++;
			$display("test %s: failed", name);
		end
		test_start_errors = errors;
	endtask

	// consumer side of the four-phase handshake
	initial
	begin
		disp_ack = 1'b0;
		forever
		begin
			step(1);
			if (disp_req)
			begin
				repeat ($urandom_range(15, 0))
					step(1);
				disp_ack = 1'b1;
				while (disp_req)
					step(1);
				disp_ack = 1'b0;
			end
		end
	end

	// each new display must match a queued entry at or after the last match
	always @(negedge dav)
	begin
		int idx;
		idx = -1;
		if (disp_req && !req_prev)
		begin
			for (int i = 0; i < exp_q.size(); i++)
				if (idx < 0 && exp_q[i] == disp_data)
					idx = i;
			assert (idx >= 0)
			else
			begin
				errors++;
				$display("Fail disp_data expected %h got %h",
					(exp_q.size() > 0) ? exp_q[0] : bcd_pos_t'('0), disp_data);
			end
			for (int i = 0; i < idx; i++)
				void'(exp_q.pop_front());
			last_disp = disp_data;
			req_count++;
		end
		req_prev = disp_req;
	end

	initial
	begin
		#(LIMIT_NS);
		$display("timeout: the display did not finish within the time limit");
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial
	begin
		int snap;
		void'($urandom(33));
		rst = 1'b1;
		ps2_clk = 1'b1;
		ps2_data = 1'b1;
		req_prev = 1'b0;
		req_count = 0;
		errors = 0;
		test_start_errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		last_disp = '1;
		model_pos.x = coord_t'(`MOUSE_HOME_X);
		model_pos.y = coord_t'(`MOUSE_HOME_Y);
		step(4);
		rst = 1'b0;

		step(100);
		assert (req_count == 0)
		else
		begin
			errors++;
			$display("disp_req rose after reset with no PS/2 traffic");
		end
		send_packet(1'b0, 1'b0, 9'sd25, -9'sd10, 1'b0);
		wait_display(to_digits(model_pos));   // 345 and 230
		end_test("reset and first packet");

		repeat (2)
			send_packet(1'b0, 1'b0, -9'sd255, -9'sd255, 1'b0);
		wait_display(to_digits(model_pos));
		repeat (4)
			send_packet(1'b0, 1'b0, 9'sd255, 9'sd255, 1'b0);
		wait_display(to_digits(model_pos));   // pinned at 639 and 479
		end_test("clamping");

		send_packet(1'b1, 1'b1, 9'sd5, 9'sd5, 1'b0);
		wait_display(to_digits(model_pos));
		end_test("recentre");

		snap = req_count;
		send_packet(1'b0, 1'b0, 9'sd7, 9'sd4, 1'b1);   // dy byte lacks bit 3, no false sync
		step(100);
		assert (req_count == snap)
		else
		begin
			errors++;
			$display("display changed after a packet with a parity error");
		end
		send_packet(1'b0, 1'b0, -9'sd3, 9'sd2, 1'b0);
		wait_display(to_digits(model_pos));
		end_test("error recovery");

		for (int i = 0; i < 40; i++)
			send_packet($urandom_range(1, 0), $urandom_range(1, 0),
				delta_t'($urandom_range(511, 0)), delta_t'($urandom_range(511, 0)), 1'b0);
		wait_display(to_digits(model_pos));
		end_test("random stream");

		$display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim.f
+incdir+hw
hw/mouse_pkg.sv
hw/ps2_rx.sv
hw/packet_assembler.sv
hw/position_tracker.sv
hw/bcd_converter.sv
hw/mouse_display_top.sv
verif/tb_mouse_display.sv
